/* common/lsqPkg.sv */
// load-store queue package
// queue sizes and the shared address, data and pointer types

package lsqPkg;

  // queue geometry, same for load and store queues
  localparam int lsqSize     = 8;  // entries per queue
  localparam int lsqIdxWidth = 3;  // log2 of lsqSize

  // word width of the memory side
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;

  // entry index into either queue
  typedef logic [lsqIdxWidth-1:0] lsqIdx_t;

  // index plus wrap bit, used for age compares
  // two pointers with equal index and different wrap bits mean a full queue
  typedef logic [lsqIdxWidth:0] lsqPtr_t;

  // occupancy, 0 to lsqSize inclusive
  typedef logic [lsqIdxWidth:0] lsqCount_t;

  // full word address, no byte lanes
  typedef logic [addrWidth-1:0] addr_t;

  // one data word
  typedef logic [dataWidth-1:0] data_t;

endpackage

/* lsq/lsqControl.sv */
// queue control for the LSU
// head/tail pointers, allocation at dispatch, retire at commit, recovery

module lsqControl (
  input  logic              clk,
  input  logic              reset,
  input  logic              recoverFlag_i,   // squash everything in flight
  input  logic              dispValid_i,
  input  logic              dispIsLoad_i,    // high for a load
  input  logic              commitLoad_i,
  input  logic              commitStore_i,
  output lsqPkg::lsqIdx_t   lsqId_o,         // allocated entry in the dispatch cycle
  output lsqPkg::lsqCount_t ldqCount_o,
  output lsqPkg::lsqCount_t stqCount_o,
  output logic              ldAlloc_o,       // write strobe into load queue
  output logic              stAlloc_o,       // write strobe into store queue
  output lsqPkg::lsqPtr_t   ldqHead_o,
  output lsqPkg::lsqPtr_t   ldqTail_o,
  output lsqPkg::lsqPtr_t   stqHead_o,
  output lsqPkg::lsqPtr_t   stqTail_o        // next store slot that loads snapshot
);

  lsqPkg::lsqPtr_t ldqHead;
  lsqPkg::lsqPtr_t ldqTail;
  lsqPkg::lsqPtr_t stqHead;
  lsqPkg::lsqPtr_t stqTail;
  lsqPkg::lsqPtr_t ldqHeadNext;
  lsqPkg::lsqPtr_t stqHeadNext;

  // heads advance by one per commit
  assign ldqHeadNext = ldqHead + lsqPkg::lsqPtr_t'(commitLoad_i);
  assign stqHeadNext = stqHead + lsqPkg::lsqPtr_t'(commitStore_i);

  // no allocation while the queues are being emptied
  assign ldAlloc_o = dispValid_i & dispIsLoad_i & ~recoverFlag_i;
  assign stAlloc_o = dispValid_i & ~dispIsLoad_i & ~recoverFlag_i;

  // id comes straight from the tail of the addressed queue
  assign lsqId_o = dispIsLoad_i ? ldqTail[lsqPkg::lsqIdxWidth-1:0]
                                : stqTail[lsqPkg::lsqIdxWidth-1:0];

  // wrap bit makes the difference exact up to 8
  assign ldqCount_o = ldqTail - ldqHead;
  assign stqCount_o = stqTail - stqHead;

  assign ldqHead_o = ldqHead;
  assign ldqTail_o = ldqTail;
  assign stqHead_o = stqHead;
  assign stqTail_o = stqTail;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ldqHead <= '0;
      ldqTail <= '0;
      stqHead <= '0;
      stqTail <= '0;
    end
    else
    begin
      ldqHead <= ldqHeadNext;  // commit still retires during recovery
      stqHead <= stqHeadNext;
      if (recoverFlag_i)
      begin
        // collapse both queues onto their heads
        ldqTail <= ldqHeadNext;
        stqTail <= stqHeadNext;
      end
      else
      begin
        ldqTail <= ldqTail + lsqPkg::lsqPtr_t'(ldAlloc_o);
        stqTail <= stqTail + lsqPkg::lsqPtr_t'(stAlloc_o);
      end
    end
  end

  // no back-pressure so the producer must watch the counts
  noOverflow: assert property (@(posedge clk) disable iff (reset)
    dispValid_i |-> (dispIsLoad_i ? ldqCount_o : stqCount_o)
                    != lsqPkg::lsqCount_t'(lsqPkg::lsqSize));

  // commit only what the queue holds
  noEmptyLdCommit: assert property (@(posedge clk) disable iff (reset)
    commitLoad_i |-> ldqCount_o != '0);

  noEmptyStCommit: assert property (@(posedge clk) disable iff (reset)
    commitStore_i |-> stqCount_o != '0);

endmodule

/* lsq/loadQueue.sv */
// load queue
// holds executed load addresses and finds loads that ran ahead of an older store

module loadQueue (
  input  logic            clk,
  input  logic            reset,
  input  logic            ldAlloc_i,
  input  lsqPkg::lsqIdx_t allocIdx_i,
  input  lsqPkg::lsqPtr_t stqTail_i,    // snapshot as store bound, also age reference
  input  lsqPkg::lsqPtr_t ldqHead_i,
  input  lsqPkg::lsqPtr_t ldqTail_i,
  input  logic            memValid_i,
  input  logic            memIsLoad_i,
  input  lsqPkg::lsqIdx_t memLsqId_i,
  input  lsqPkg::addr_t   memAddr_i,
  output lsqPkg::lsqPtr_t ldStBound_o,  // bound of the executing load
  output logic            vioHit_o,
  output lsqPkg::lsqIdx_t vioLqId_o
);

  lsqPkg::addr_t   entryAddr  [lsqPkg::lsqSize];
  lsqPkg::lsqPtr_t entryBound [lsqPkg::lsqSize];  // store tail at dispatch
  logic [lsqPkg::lsqSize-1:0] executed;

  logic ldExec;
  logic stExec;

  assign ldExec = memValid_i & memIsLoad_i;
  assign stExec = memValid_i & ~memIsLoad_i;

  // executed flags are control state
  always_ff @(posedge clk)
  begin
    if (reset)
      executed <= '0;
    else
    begin
      if (ldAlloc_i)
        executed[allocIdx_i] <= 1'b0;
      if (ldExec)
        executed[memLsqId_i] <= 1'b1;
    end
  end

  // payload, no reset
  always_ff @(posedge clk)
  begin
    if (ldAlloc_i)
      entryBound[allocIdx_i] <= stqTail_i;
    if (ldExec)
      entryAddr[memLsqId_i] <= memAddr_i;
  end

  assign ldStBound_o = entryBound[memLsqId_i];

  // violation search, walks from ldq head so the first hit is the oldest load
  always_comb
  begin
    lsqPkg::lsqCount_t liveCnt;
    lsqPkg::lsqIdx_t   idx;
    lsqPkg::lsqIdx_t   stDist3;
    lsqPkg::lsqCount_t stDist;
    lsqPkg::lsqCount_t ldDist;
    liveCnt = ldqTail_i - ldqHead_i;
    stDist3 = stqTail_i[lsqPkg::lsqIdxWidth-1:0] - memLsqId_i;  // store distance to tail
    stDist = (stDist3 == '0) ? lsqPkg::lsqCount_t'(lsqPkg::lsqSize)
                             : lsqPkg::lsqCount_t'(stDist3);  // 0 only when full
    vioHit_o = 1'b0;
    vioLqId_o = '0;
    for (int k = 0; k < lsqPkg::lsqSize; k++)
    begin
      idx = ldqHead_i[lsqPkg::lsqIdxWidth-1:0] + lsqPkg::lsqIdx_t'(k);
      ldDist = stqTail_i - entryBound[idx];  // smaller means bound is past the store
      if (!vioHit_o && stExec && k < liveCnt && executed[idx] &&
          ldDist < stDist && entryAddr[idx] == memAddr_i)
      begin
        vioHit_o = 1'b1;
        vioLqId_o = idx;
      end
    end
  end

endmodule

/* lsq/storeQueue.sv */
// store queue
// store address/data, store-to-load forwarding search and in-order commit write

module storeQueue (
  input  logic            clk,
  input  logic            reset,
  input  logic            stAlloc_i,
  input  lsqPkg::lsqIdx_t allocIdx_i,
  input  lsqPkg::lsqPtr_t stqHead_i,
  input  lsqPkg::lsqPtr_t ldStBound_i,   // first store younger than the load
  input  logic            memValid_i,
  input  logic            memIsLoad_i,
  input  lsqPkg::lsqIdx_t memLsqId_i,
  input  lsqPkg::addr_t   memAddr_i,
  input  lsqPkg::data_t   memData_i,
  input  logic            commitStore_i,
  output logic            fwdHit_o,
  output lsqPkg::data_t   fwdData_o,
  output logic            stEn_o,        // memory write, same cycle as commit
  output lsqPkg::addr_t   stAddr_o,
  output lsqPkg::data_t   stData_o
);

  lsqPkg::addr_t entryAddr [lsqPkg::lsqSize];
  lsqPkg::data_t entryData [lsqPkg::lsqSize];
  logic [lsqPkg::lsqSize-1:0] addrValid;  // address known, store has executed

  logic [lsqPkg::lsqSize-1:0] ageMask;    // stores older than the executing load
  logic [lsqPkg::lsqSize-1:0] addrMatch;
  lsqPkg::lsqIdx_t fwdSel;
  lsqPkg::lsqIdx_t headIdx;
  logic stExec;

  assign stExec  = memValid_i & ~memIsLoad_i;
  assign headIdx = stqHead_i[lsqPkg::lsqIdxWidth-1:0];

  always_ff @(posedge clk)
  begin
    if (reset)
      addrValid <= '0;
    else
    begin
      if (stAlloc_i)
        addrValid[allocIdx_i] <= 1'b0;  // new store, address unknown
      if (stExec)
        addrValid[memLsqId_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (stExec)
    begin
      entryAddr[memLsqId_i] <= memAddr_i;
      entryData[memLsqId_i] <= memData_i;
    end
  end

  // age mask from head up to the bound, CAM on the address
  always_comb
  begin
    lsqPkg::lsqCount_t olderCnt;
    lsqPkg::lsqIdx_t   idx;
    olderCnt = ldStBound_i - stqHead_i;
    if (olderCnt > lsqPkg::lsqCount_t'(lsqPkg::lsqSize))
      olderCnt = '0;  // head already passed the bound, all older stores gone
    for (int k = 0; k < lsqPkg::lsqSize; k++)
    begin
      idx = headIdx + lsqPkg::lsqIdx_t'(k);
      ageMask[idx] = (k < olderCnt);
      addrMatch[idx] = addrValid[idx] && (entryAddr[idx] == memAddr_i);  // unknown never hits
    end
  end

  // walk oldest to youngest, last hit wins, so youngest older store forwards
  always_comb
  begin
    lsqPkg::lsqIdx_t idx;
    fwdHit_o = 1'b0;
    fwdSel = '0;
    for (int k = 0; k < lsqPkg::lsqSize; k++)
    begin
      idx = headIdx + lsqPkg::lsqIdx_t'(k);
      if (memValid_i && memIsLoad_i && ageMask[idx] && addrMatch[idx])
      begin
        fwdHit_o = 1'b1;
        fwdSel = idx;
      end
    end
  end

  assign fwdData_o = entryData[fwdSel];

  // commit writes the head entry to memory
  assign stEn_o   = commitStore_i;
  assign stAddr_o = entryAddr[headIdx];
  assign stData_o = entryData[headIdx];

  // a store must have executed before it reaches commit
  headExecuted: assert property (@(posedge clk) disable iff (reset)
    commitStore_i |-> addrValid[headIdx]);

endmodule

/* source/lsuWriteback.sv */
// LSU result stage
// registers the execute outcome, merges forwarded data with memory data

module lsuWriteback (
  input  logic            clk,
  input  logic            reset,
  input  logic            memValid_i,
  input  logic            memIsLoad_i,
  input  lsqPkg::lsqIdx_t memLsqId_i,
  input  logic            fwdHit_i,
  input  lsqPkg::data_t   fwdData_i,
  input  logic            vioHit_i,
  input  lsqPkg::lsqIdx_t vioLqId_i,
  input  lsqPkg::data_t   ldData_i,     // memory, one cycle after ldEn
  output logic            wbValid_o,
  output lsqPkg::lsqIdx_t wbLqId_o,
  output lsqPkg::data_t   wbData_o,
  output logic            ldVioValid_o,
  output lsqPkg::lsqIdx_t ldVioLqId_o
);

  logic          fwdHitQ;
  lsqPkg::data_t fwdDataQ;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wbValid_o    <= 1'b0;
      ldVioValid_o <= 1'b0;
    end
    else
    begin
      wbValid_o    <= memValid_i & memIsLoad_i;
      ldVioValid_o <= vioHit_i;  // only raised by an executing store
    end
  end

  always_ff @(posedge clk)
  begin
    wbLqId_o    <= memLsqId_i;
    fwdHitQ     <= fwdHit_i;
    fwdDataQ    <= fwdData_i;
    ldVioLqId_o <= vioLqId_i;
  end

  // store queue wins over memory
  assign wbData_o = fwdHitQ ? fwdDataQ : ldData_i;

endmodule

/* source/lsuTop.sv */
// load-store unit top
// control, load queue, store queue and writeback for one dispatch and one commit lane

module lsuTop (
  input  logic              clk,
  input  logic              reset,
  input  logic              recoverFlag_i,
  input  logic              dispValid_i,
  input  logic              dispIsLoad_i,
  output lsqPkg::lsqIdx_t   lsqId_o,
  input  logic              commitLoad_i,
  input  logic              commitStore_i,
  input  logic              memValid_i,
  input  logic              memIsLoad_i,
  input  lsqPkg::lsqIdx_t   memLsqId_i,
  input  lsqPkg::addr_t     memAddr_i,
  input  lsqPkg::data_t     memData_i,     // store data, unused for loads
  output lsqPkg::lsqCount_t ldqCount_o,
  output lsqPkg::lsqCount_t stqCount_o,
  output logic              wbValid_o,
  output lsqPkg::lsqIdx_t   wbLqId_o,
  output lsqPkg::data_t     wbData_o,
  output logic              ldVioValid_o,
  output lsqPkg::lsqIdx_t   ldVioLqId_o,
  output logic              ldEn_o,
  output lsqPkg::addr_t     ldAddr_o,
  input  lsqPkg::data_t     ldData_i,
  output logic              stEn_o,
  output lsqPkg::addr_t     stAddr_o,
  output lsqPkg::data_t     stData_o
);

  logic            ldAlloc;
  logic            stAlloc;
  lsqPkg::lsqPtr_t ldqHead;
  lsqPkg::lsqPtr_t ldqTail;
  lsqPkg::lsqPtr_t stqHead;
  lsqPkg::lsqPtr_t stqTail;
  lsqPkg::lsqPtr_t ldStBound;
  logic            fwdHit;
  lsqPkg::data_t   fwdData;
  logic            vioHit;
  lsqPkg::lsqIdx_t vioLqId;

  // memory read runs in parallel with the store queue search
  assign ldEn_o   = memValid_i & memIsLoad_i;
  assign ldAddr_o = memAddr_i;

  lsqControl control_i (
    .clk, .reset, .recoverFlag_i, .dispValid_i, .dispIsLoad_i,
    .commitLoad_i, .commitStore_i, .lsqId_o, .ldqCount_o, .stqCount_o,
    .ldAlloc_o(ldAlloc), .stAlloc_o(stAlloc),
    .ldqHead_o(ldqHead), .ldqTail_o(ldqTail),
    .stqHead_o(stqHead), .stqTail_o(stqTail)
  );

  loadQueue ldq_i (
    .clk, .reset, .ldAlloc_i(ldAlloc), .allocIdx_i(lsqId_o),
    .stqTail_i(stqTail), .ldqHead_i(ldqHead), .ldqTail_i(ldqTail),
    .memValid_i, .memIsLoad_i, .memLsqId_i, .memAddr_i,
    .ldStBound_o(ldStBound), .vioHit_o(vioHit), .vioLqId_o(vioLqId)
  );

  storeQueue stq_i (
    .clk, .reset, .stAlloc_i(stAlloc), .allocIdx_i(lsqId_o),
    .stqHead_i(stqHead), .ldStBound_i(ldStBound),
    .memValid_i, .memIsLoad_i, .memLsqId_i, .memAddr_i, .memData_i,
    .commitStore_i, .fwdHit_o(fwdHit), .fwdData_o(fwdData),
    .stEn_o, .stAddr_o, .stData_o
  );

  lsuWriteback wb_i (
    .clk, .reset, .memValid_i, .memIsLoad_i, .memLsqId_i,
    .fwdHit_i(fwdHit), .fwdData_i(fwdData),
    .vioHit_i(vioHit), .vioLqId_i(vioLqId), .ldData_i,
    .wbValid_o, .wbLqId_o, .wbData_o, .ldVioValid_o, .ldVioLqId_o
  );

endmodule

/* verif/lsuTb.sv */
// LSU testbench
// directed load/store sequences checked by assertions against a program-order scoreboard

module lsuTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int wbTimeout = 8;  // cycles to wait for a load result

  logic              clk;
  logic              reset;
  logic              recoverFlag;
  logic              dispValid;
  logic              dispIsLoad;
  logic              commitLoad;
  logic              commitStore;
  logic              memValid;
  logic              memIsLoad;
  lsqPkg::lsqIdx_t   memLsqId;
  lsqPkg::addr_t     memAddr;
  lsqPkg::data_t     memData;
  lsqPkg::data_t     ldData = '0;
  lsqPkg::lsqIdx_t   lsqId;
  lsqPkg::lsqCount_t ldqCount;
  lsqPkg::lsqCount_t stqCount;
  logic              wbValid;
  lsqPkg::lsqIdx_t   wbLqId;
  lsqPkg::data_t     wbData;
  logic              ldVioValid;
  lsqPkg::lsqIdx_t   ldVioLqId;
  logic              ldEn;
  lsqPkg::addr_t     ldAddr;
  logic              stEn;
  lsqPkg::addr_t     stAddr;
  lsqPkg::data_t     stData;

  // expectations driven next to the stimulus
  lsqPkg::lsqIdx_t   expId;
  lsqPkg::lsqCount_t expLdCnt;
  lsqPkg::lsqCount_t expStCnt;
  lsqPkg::data_t     expWbData;
  logic              expVio;
  lsqPkg::lsqIdx_t   expVioId;
  lsqPkg::addr_t     expStAddr;
  lsqPkg::data_t     expStData;
  // the same expectations delayed to the result cycle
  logic              resetQ;
  logic              ldExecQ;
  logic              stExecQ;
  lsqPkg::data_t     expWbDataQ;
  lsqPkg::lsqIdx_t   expWbIdQ;
  logic              expVioQ;
  lsqPkg::lsqIdx_t   expVioIdQ;
  lsqPkg::lsqCount_t expLdCntQ;
  lsqPkg::lsqCount_t expStCntQ;

  // scoreboard ordering entries by sequence number
  int              refLdHead;
  int              refLdCnt;
  int              refStHead;
  int              refStCnt;
  int              refSeq;
  int              refLdSeq  [lsqPkg::lsqSize];
  bit              refLdDone [lsqPkg::lsqSize];
  lsqPkg::addr_t   refLdAddr [lsqPkg::lsqSize];
  int              refStSeq  [lsqPkg::lsqSize];
  bit              refStDone [lsqPkg::lsqSize];
  lsqPkg::addr_t   refStAddr [lsqPkg::lsqSize];
  lsqPkg::data_t   refStData [lsqPkg::lsqSize];
  lsqPkg::data_t   refMem    [lsqPkg::addr_t];  // committed words
  lsqPkg::data_t   memArray  [lsqPkg::addr_t];  // memory model contents

  int errors;
  int errStart;
  int testCount;
  int failCount;

  lsuTop dut_i (
    .clk, .reset, .recoverFlag_i(recoverFlag), .dispValid_i(dispValid),
    .dispIsLoad_i(dispIsLoad), .lsqId_o(lsqId), .commitLoad_i(commitLoad),
    .commitStore_i(commitStore), .memValid_i(memValid), .memIsLoad_i(memIsLoad),
    .memLsqId_i(memLsqId), .memAddr_i(memAddr), .memData_i(memData),
    .ldqCount_o(ldqCount), .stqCount_o(stqCount), .wbValid_o(wbValid),
    .wbLqId_o(wbLqId), .wbData_o(wbData), .ldVioValid_o(ldVioValid),
    .ldVioLqId_o(ldVioLqId), .ldEn_o(ldEn), .ldAddr_o(ldAddr), .ldData_i(ldData),
    .stEn_o(stEn), .stAddr_o(stAddr), .stData_o(stData)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // memory model with a one cycle read that sees the old word on a commit
  always @(posedge clk)
  begin
    if (ldEn)
      ldData <= memArray.exists(ldAddr) ? memArray[ldAddr] : ldAddr;  // unwritten reads its address
    if (stEn)
      memArray[stAddr] = stData;
  end

  always_ff @(posedge clk)
  begin
    resetQ     <= reset;
    ldExecQ    <= memValid & memIsLoad;
    stExecQ    <= memValid & ~memIsLoad;
    expWbDataQ <= expWbData;
    expWbIdQ   <= memLsqId;
    expVioQ    <= expVio;
    expVioIdQ  <= expVioId;
    expLdCntQ  <= expLdCnt;  // counts move on the edge after the request
    expStCntQ  <= expStCnt;
  end

  resetState: assert property (@(posedge clk) disable iff (reset)
    resetQ |-> ldqCount == '0 && stqCount == '0 && !wbValid && !ldVioValid && !ldEn && !stEn)
  else
  begin
    errors++;
    $display("ERR ldqCount_o/stqCount_o after reset got %h/%h exp 0/0",
             $sampled(ldqCount), $sampled(stqCount));
    $display("ERR wbValid_o/ldVioValid_o/ldEn_o/stEn_o after reset got %h/%h/%h/%h exp 0/0/0/0",
             $sampled(wbValid), $sampled(ldVioValid), $sampled(ldEn), $sampled(stEn));
  end

  dispatchId: assert property (@(posedge clk) disable iff (reset) dispValid |-> lsqId == expId)
  else
  begin
    errors++;
    $display("ERR lsqId_o got %h exp %h", $sampled(lsqId), $sampled(expId));
  end

  ldCount: assert property (@(posedge clk) disable iff (reset) ldqCount == expLdCntQ)
  else
  begin
    errors++;
    $display("ERR ldqCount_o got %h exp %h", $sampled(ldqCount), $sampled(expLdCntQ));
  end

  stCount: assert property (@(posedge clk) disable iff (reset) stqCount == expStCntQ)
  else
  begin
    errors++;
    $display("ERR stqCount_o got %h exp %h", $sampled(stqCount), $sampled(expStCntQ));
  end

  // forwarded or memory data one cycle after execute
  loadResult: assert property (@(posedge clk) disable iff (reset)
    ldExecQ |-> wbValid && wbLqId == expWbIdQ && wbData == expWbDataQ)
  else
  begin
    errors++;
    $display("ERR wbValid_o got %h exp 1, wbData_o got %h exp %h, wbLqId_o got %h exp %h",
             $sampled(wbValid), $sampled(wbData), $sampled(expWbDataQ), $sampled(wbLqId),
             $sampled(expWbIdQ));
  end

  loadViolation: assert property (@(posedge clk) disable iff (reset)
    stExecQ |-> ldVioValid == expVioQ && (!expVioQ || ldVioLqId == expVioIdQ))
  else
  begin
    errors++;
    $display("ERR ldVioValid_o got %h exp %h, ldVioLqId_o got %h exp %h", $sampled(ldVioValid),
             $sampled(expVioQ), $sampled(ldVioLqId), $sampled(expVioIdQ));
  end

  loadPort: assert property (@(posedge clk) disable iff (reset)
    ldEn == (memValid && memIsLoad) && (!ldEn || ldAddr == memAddr))
  else
  begin
    errors++;
    $display("ERR ldEn_o/ldAddr_o got %h/%h exp %h/%h", $sampled(ldEn), $sampled(ldAddr),
             $sampled(memValid && memIsLoad), $sampled(memAddr));
  end

  storePort: assert property (@(posedge clk) disable iff (reset)
    commitStore |-> stEn && stAddr == expStAddr && stData == expStData)
  else
  begin
    errors++;
    $display("ERR stAddr_o/stData_o got %h/%h exp %h/%h", $sampled(stAddr), $sampled(stData),
             $sampled(expStAddr), $sampled(expStData));
  end

  strayStrobe: assert property (@(posedge clk) disable iff (reset)
    (ldExecQ || !wbValid) && (stExecQ || !ldVioValid) && (commitStore || !stEn))
  else
  begin
    errors++;
    $display("ERR wbValid_o/ldVioValid_o/stEn_o got %h/%h/%h with requests %h/%h/%h",
             $sampled(wbValid), $sampled(ldVioValid), $sampled(stEn),
             $sampled(ldExecQ), $sampled(stExecQ), $sampled(commitStore));
  end

  function automatic lsqPkg::addr_t pickAddr();
    return 32'h0000_0100 + 32'($urandom % 4) * 4;  // small pool for frequent aliasing
  endfunction

  function automatic lsqPkg::data_t memValue(lsqPkg::addr_t a);
    return refMem.exists(a) ? refMem[a] : a;
  endfunction

  // youngest older executed store at the address or else memory
  function automatic lsqPkg::data_t predictLoad(int id, lsqPkg::addr_t a);
    lsqPkg::data_t d;
    int idx;
    d = memValue(a);
    for (int k = 0; k < refStCnt; k++)
    begin
      idx = (refStHead + k) % lsqPkg::lsqSize;
      if (refStSeq[idx] < refLdSeq[id] && refStDone[idx] && refStAddr[idx] == a)
        d = refStData[idx];  // walk runs old to young
    end
    return d;
  endfunction

  // oldest younger executed load at the address or -1
  function automatic int predictViolation(int id, lsqPkg::addr_t a);
    int idx;
    for (int k = 0; k < refLdCnt; k++)
    begin
      idx = (refLdHead + k) % lsqPkg::lsqSize;
      if (refLdSeq[idx] > refStSeq[id] && refLdDone[idx] && refLdAddr[idx] == a)
        return idx;
    end
    return -1;
  endfunction

  task automatic clearInputs();
    recoverFlag <= 1'b0;
    dispValid   <= 1'b0;
    commitLoad  <= 1'b0;
    commitStore <= 1'b0;
    memValid    <= 1'b0;
  endtask

  task automatic publishCounts();
    expLdCnt <= lsqPkg::lsqCount_t'(refLdCnt);
    expStCnt <= lsqPkg::lsqCount_t'(refStCnt);
  endtask

  task automatic idle(int n);
    repeat (n)
    begin
      @(posedge clk);
      clearInputs();
    end
  endtask

  task automatic dispatch(bit isLoad, output int id);
    @(posedge clk);
    clearInputs();
    dispValid  <= 1'b1;
    dispIsLoad <= isLoad;
    refSeq++;
    if (isLoad)
    begin
      id = (refLdHead + refLdCnt) % lsqPkg::lsqSize;  // next free slot
      refLdSeq[id]  = refSeq;
      refLdDone[id] = 1'b0;
      refLdCnt++;
    end
    else
    begin
      id = (refStHead + refStCnt) % lsqPkg::lsqSize;
      refStSeq[id]  = refSeq;
      refStDone[id] = 1'b0;
      refStCnt++;
    end
    expId <= lsqPkg::lsqIdx_t'(id);
    publishCounts();
  endtask

  task automatic execLoad(int id, lsqPkg::addr_t a);
    int waited;
    @(posedge clk);
    clearInputs();
    memValid  <= 1'b1;
    memIsLoad <= 1'b1;
    memLsqId  <= lsqPkg::lsqIdx_t'(id);
    memAddr   <= a;
    memData   <= $urandom;  // ignored by loads
    expWbData <= predictLoad(id, a);
    refLdDone[id] = 1'b1;
    refLdAddr[id] = a;
    @(posedge clk);
    clearInputs();
    waited = 0;
    while (!wbValid && waited < wbTimeout)
    begin
      @(posedge clk);
      waited++;
    end
    if (!wbValid)
    begin
      $display("load %0d got no writeback within %0d cycles", id, wbTimeout);
      $display("Simulation failed");
      $finish;
    end
  endtask

  task automatic execStore(int id, lsqPkg::addr_t a, lsqPkg::data_t d);
    int vid;
    @(posedge clk);
    clearInputs();
    memValid  <= 1'b1;
    memIsLoad <= 1'b0;
    memLsqId  <= lsqPkg::lsqIdx_t'(id);
    memAddr   <= a;
    memData   <= d;
    vid = predictViolation(id, a);
    expVio   <= (vid >= 0);
    expVioId <= lsqPkg::lsqIdx_t'(vid);
    refStDone[id] = 1'b1;
    refStAddr[id] = a;
    refStData[id] = d;
  endtask

  task automatic retireLoad();
    @(posedge clk);
    clearInputs();
    commitLoad <= 1'b1;
    refLdHead = (refLdHead + 1) % lsqPkg::lsqSize;
    refLdCnt--;
    publishCounts();
  endtask

  task automatic retireStore();
    @(posedge clk);
    clearInputs();
    commitStore <= 1'b1;
    expStAddr   <= refStAddr[refStHead];
    expStData   <= refStData[refStHead];
    refMem[refStAddr[refStHead]] = refStData[refStHead];  // visible to later loads
    refStHead = (refStHead + 1) % lsqPkg::lsqSize;
    refStCnt--;
    publishCounts();
  endtask

  task automatic recover();
    @(posedge clk);
    clearInputs();
    recoverFlag <= 1'b1;
    refLdCnt = 0;  // tails fall back onto heads
    refStCnt = 0;
    publishCounts();
  endtask

  task automatic endTest(string name);
    idle(3);  // let the last result reach the checks
    testCount++;
    if (errors != errStart)
      failCount++;
    $display("test %0d %s: %s", testCount, name, (errors == errStart) ? "ok" : "FAILED");
    errStart = errors;
  endtask

  initial
  begin
    int id;
    int ids [8];
    lsqPkg::addr_t a;
    void'($urandom(24355));
    reset <= 1'b1;
    clearInputs();
    dispIsLoad <= 1'b0;
    memIsLoad  <= 1'b0;
    memLsqId   <= '0;
    memAddr    <= '0;
    memData    <= '0;
    expId      <= '0;
    expWbData  <= '0;
    expVio     <= 1'b0;
    expVioId   <= '0;
    expStAddr  <= '0;
    expStData  <= '0;
    publishCounts();
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    endTest("reset state");

    // load ids wrap after two rounds of six
    for (int r = 0; r < 2; r++)
    begin
      for (int k = 0; k < 6; k++)
        dispatch(1'b1, id);
      for (int k = 0; k < 6; k++)
        retireLoad();
    end
    for (int k = 0; k < 8; k++)
      dispatch(1'b0, ids[k]);  // fills the store queue
    for (int k = 0; k < 8; k++)
      execStore(ids[k], pickAddr(), $urandom);
    for (int k = 0; k < 8; k++)
      retireStore();
    endTest("dispatch ids and counts");

    for (int k = 0; k < 4; k++)
      dispatch(1'b1, ids[k]);
    for (int k = 0; k < 4; k++)
      execLoad(ids[k], (k == 0) ? 32'h0000_0200 : pickAddr());  // first one never written
    for (int k = 0; k < 4; k++)
      retireLoad();
    endTest("load from memory");

    a = pickAddr();  // one address so a reused slot keeps a stale match
    for (int r = 0; r < 3; r++)
    begin
      dispatch(1'b0, ids[0]);
      dispatch(1'b0, ids[1]);
      dispatch(1'b0, ids[2]);  // stays unknown until after the load
      dispatch(1'b1, ids[4]);
      dispatch(1'b0, ids[3]);  // younger than the load
      execStore(ids[0], a, $urandom);
      execStore(ids[1], a, $urandom);
      execStore(ids[3], a, $urandom);
      execLoad(ids[4], a);
      execStore(ids[2], a, $urandom);  // late store also flags the load
      for (int k = 0; k < 4; k++)
        retireStore();
      retireLoad();
    end
    endTest("store to load forwarding");

    a = pickAddr();
    dispatch(1'b0, ids[0]);
    dispatch(1'b1, ids[1]);
    dispatch(1'b1, ids[2]);
    dispatch(1'b0, ids[3]);
    execLoad(ids[2], a);  // young load runs first
    execLoad(ids[1], a);
    execStore(ids[3], a, $urandom);  // younger store raises no violation
    execStore(ids[0], a, $urandom);  // flags ids[1]
    retireStore();
    retireStore();
    retireLoad();
    retireLoad();
    endTest("load violation");

    dispatch(1'b0, ids[0]);
    execStore(ids[0], pickAddr(), $urandom);
    retireStore();
    a = pickAddr();
    dispatch(1'b1, ids[1]);
    dispatch(1'b0, ids[2]);
    dispatch(1'b1, ids[3]);
    execStore(ids[2], a, $urandom);
    recover();
    dispatch(1'b1, ids[4]);  // reuses the head slot
    execLoad(ids[4], a);  // squashed store at the same address must not forward
    retireLoad();
    endTest("commit and recovery");

    $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errors);
    if (errors == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
common/lsqPkg.sv
lsq/lsqControl.sv
lsq/loadQueue.sv
lsq/storeQueue.sv
source/lsuWriteback.sv
source/lsuTop.sv
verif/lsuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsuTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run passes only when the pass message shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
